// File: design/fifo_pkg.sv
// FIFO package with the sizes and the packed structs shared by the FIFO blocks
package fifo_pkg;

  // --------------------
  // Sizes
  // --------------------

  // Total capacity, output register included
  localparam int DEPTH = 4;

  // Bits per data item
  localparam int WIDTH = 8;

  // Storage address width
  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // Count range is 0 to DEPTH inclusive
  localparam int COUNT_WIDTH = $clog2(DEPTH) + 1;

  // --------------------
  // Shared structs
  // --------------------

  // Push side status
  typedef struct packed {
    logic                   full;
    logic [COUNT_WIDTH-1:0] slots;
  } push_status_t;

  // Pop side status
  typedef struct packed {
    logic                   empty;
    logic [COUNT_WIDTH-1:0] items;
  } pop_status_t;

  // One write into the storage array
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WIDTH-1:0]      data;
  } ram_wr_t;

  // Item offered on the bypass path, not qualified by the handshake
  typedef struct packed {
    logic             valid;
    logic [WIDTH-1:0] data;
  } bypass_t;

endpackage : fifo_pkg

// File: design/fifo_pop_ctrl.sv
// FIFO pop controller with read addressing, item counting and the registered output stage
`timescale 1ns/100ps

module fifo_pop_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  // From the push controller
  input  logic                            push_beat,
  input  fifo_pkg::bypass_t               bypass,
  input  logic                            ram_written,
  // Storage read port
  output logic [fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
  input  logic [fifo_pkg::WIDTH-1:0]      rd_data,
  // To the push controller
  output logic                            bypass_ready,
  // Pop side handshake
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output logic [fifo_pkg::WIDTH-1:0]      pop_data,
  output logic                            pop_beat,
  // Pop side status
  output fifo_pkg::pop_status_t           status
);

  logic [fifo_pkg::COUNT_WIDTH-1:0] ram_items;
  logic [fifo_pkg::COUNT_WIDTH-1:0] items;
  logic [fifo_pkg::COUNT_WIDTH-1:0] items_next;
  logic                             empty;
  logic                             ram_empty;
  logic                             refill;
  logic                             load_ram;
  logic                             load_bypass;

  // --------------------
  // Output stage control
  // --------------------

  assign pop_beat  = pop_valid && pop_ready;
  assign ram_empty = (ram_items == '0);

  // Output register can take a new item this cycle
  assign refill = !pop_valid || pop_ready;

  // Bypass only when storage has nothing older
  assign bypass_ready = ram_empty && refill;

  // Storage has priority to keep ordering
  assign load_ram    = refill && !ram_empty;
  assign load_bypass = bypass_ready && push_beat && bypass.valid;

  // Valid bit of the output register
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_valid <= 1'b0;
    end else if (refill) begin
      pop_valid <= load_ram || load_bypass;
    end
  end

  // Output data register
  always_ff @(posedge clk) begin
    if (load_ram) begin
      pop_data <= rd_data;
    end else if (load_bypass) begin
      pop_data <= bypass.data;
    end
  end

  // --------------------
  // Storage tracking
  // --------------------

  // Occupancy and read address follow storage writes and loads
  always_ff @(posedge clk) begin
    if (rst) begin
      ram_items <= '0;
      rd_addr   <= '0;
    end else begin
      // A write and a load in the same cycle cancel out
      if (ram_written && !load_ram) begin
        ram_items <= ram_items + fifo_pkg::COUNT_WIDTH'(1);
      end else if (!ram_written && load_ram) begin
        ram_items <= ram_items - fifo_pkg::COUNT_WIDTH'(1);
      end
      if (load_ram) begin
        if (rd_addr == fifo_pkg::ADDR_WIDTH'(fifo_pkg::DEPTH - 1)) begin
          rd_addr <= '0;
        end else begin
          rd_addr <= rd_addr + fifo_pkg::ADDR_WIDTH'(1);
        end
      end
    end
  end

  // Items in storage plus the output register
  always_comb begin
    case ({push_beat, pop_beat})
      2'b10:   items_next = items + fifo_pkg::COUNT_WIDTH'(1);
      2'b01:   items_next = items - fifo_pkg::COUNT_WIDTH'(1);
      default: items_next = items;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
      empty <= 1'b1;
    end else begin
      items <= items_next;
      if (push_beat || pop_beat) begin
        empty <= (items_next == '0);
      end
    end
  end

  assign status.empty = empty;
  assign status.items = items;

endmodule : fifo_pop_ctrl

// File: design/fifo_push_ctrl.sv
// FIFO push controller with flow control, write addressing, slot counting and bypass steering
`timescale 1ns/100ps

module fifo_push_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  // Push side handshake
  input  logic                         push_valid,
  input  logic [fifo_pkg::WIDTH-1:0]   push_data,
  output logic                         push_ready,
  // From the pop controller
  input  logic                         bypass_ready,
  input  logic                         pop_beat,
  // To the pop controller
  output logic                         push_beat,
  output fifo_pkg::bypass_t            bypass,
  // Storage write port
  output fifo_pkg::ram_wr_t            ram_wr,
  // Push side status
  output fifo_pkg::push_status_t       status
);

  logic [fifo_pkg::ADDR_WIDTH-1:0]  wr_addr;
  logic [fifo_pkg::COUNT_WIDTH-1:0] slots;
  logic [fifo_pkg::COUNT_WIDTH-1:0] slots_next;
  logic                             full;

  // --------------------
  // Flow control
  // --------------------

  // Ready comes straight off the registered full flag
  assign push_ready = !full;
  assign push_beat  = push_valid && push_ready;

  // Bypass carries the raw push inputs
  assign bypass.valid = push_valid;
  assign bypass.data  = push_data;

  // Storage only sees beats the pop side cannot take directly
  assign ram_wr.valid = push_beat && !bypass_ready;
  assign ram_wr.addr  = wr_addr;
  assign ram_wr.data  = push_data;

  // Write address, wraps after the last word
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr <= '0;
    end else if (ram_wr.valid) begin
      if (wr_addr == fifo_pkg::ADDR_WIDTH'(fifo_pkg::DEPTH - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + fifo_pkg::ADDR_WIDTH'(1);
      end
    end
  end

  // --------------------
  // Slot counting
  // --------------------

  // Push takes a slot, pop frees one, both at once cancel out
  always_comb begin
    case ({push_beat, pop_beat})
      2'b10:   slots_next = slots - fifo_pkg::COUNT_WIDTH'(1);
      2'b01:   slots_next = slots + fifo_pkg::COUNT_WIDTH'(1);
      default: slots_next = slots;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slots <= fifo_pkg::COUNT_WIDTH'(fifo_pkg::DEPTH);
      full  <= 1'b0;
    end else begin
      slots <= slots_next;
      // Full only moves on a beat
      if (push_beat || pop_beat) begin
        full <= (slots_next == '0);
      end
    end
  end

  assign status.full  = full;
  assign status.slots = slots;

endmodule : fifo_push_ctrl

// File: design/fifo_ram.sv
// FIFO storage array, one synchronous write port and one combinational read port
`timescale 1ns/100ps

module fifo_ram (
  input  logic                            clk,
  // Write port
  input  fifo_pkg::ram_wr_t               wr,
  // Read port
  input  logic [fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [fifo_pkg::WIDTH-1:0]      rd_data
);

  // --------------------
  // Storage
  // --------------------

  // Flop based words, contents undefined until written
  logic [fifo_pkg::WIDTH-1:0] mem [fifo_pkg::DEPTH];

  // Write lands on the edge
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read is combinational, same cycle as the address
  assign rd_data = mem[rd_addr];

endmodule : fifo_ram

// File: design/fifo_top.sv
// FIFO top level joining the push controller, the storage array and the pop controller
`timescale 1ns/100ps

module fifo_top (
  input  logic                       clk,
  input  logic                       rst,
  // Push side
  input  logic                       push_valid,
  input  logic [fifo_pkg::WIDTH-1:0] push_data,
  output logic                       push_ready,
  // Pop side
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output logic [fifo_pkg::WIDTH-1:0] pop_data,
  // Status
  output fifo_pkg::push_status_t     push_status,
  output fifo_pkg::pop_status_t      pop_status
);

  // --------------------
  // Internal wires
  // --------------------

  // Handshakes between controllers
  logic                            push_beat;
  logic                            pop_beat;
  logic                            bypass_ready;
  fifo_pkg::bypass_t               bypass;

  // Storage ports
  fifo_pkg::ram_wr_t               ram_wr;
  logic [fifo_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [fifo_pkg::WIDTH-1:0]      rd_data;

  // Push side flow control and storage writes
  fifo_push_ctrl u_push_ctrl (
    .clk          (clk),
    .rst          (rst),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .bypass_ready (bypass_ready),
    .pop_beat     (pop_beat),
    .push_beat    (push_beat),
    .bypass       (bypass),
    .ram_wr       (ram_wr),
    .status       (push_status)
  );

  // Storage
  fifo_ram u_ram (
    .clk     (clk),
    .wr      (ram_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Pop side, write strobe doubles as storage occupancy increment
  fifo_pop_ctrl u_pop_ctrl (
    .clk          (clk),
    .rst          (rst),
    .push_beat    (push_beat),
    .bypass       (bypass),
    .ram_written  (ram_wr.valid),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .bypass_ready (bypass_ready),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .pop_beat     (pop_beat),
    .status       (pop_status)
  );

endmodule : fifo_top

// File: files.f
design/fifo_pkg.sv
design/fifo_ram.sv
design/fifo_push_ctrl.sv
design/fifo_pop_ctrl.sv
design/fifo_top.sv
tests/fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f files.f --top-module fifo_tb -o fifo_sim

# The log decides the result, a failing run ends early
./obj_dir/fifo_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: tests/fifo_tb.sv
// FIFO testbench, drives a stimulus table and checks every cycle against a queue model
`timescale 1ns/100ps

module fifo_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_ROWS  = 200;
  localparam int MARGIN_ROWS  = 20;

  logic                       clk;
  logic                       rst;
  logic                       push_valid;
  logic [fifo_pkg::WIDTH-1:0] push_data;
  logic                       push_ready;
  logic                       pop_ready;
  logic                       pop_valid;
  logic [fifo_pkg::WIDTH-1:0] pop_data;
  fifo_pkg::push_status_t     push_status;
  fifo_pkg::pop_status_t      pop_status;

  // Stimulus table, one row per cycle
  logic  pv_tbl[$];
  logic  pr_tbl[$];
  string name_tbl[$];
  logic  table_built;

  // Reference queue, head is the item on pop_data
  logic [fifo_pkg::WIDTH-1:0] model_q[$];
  logic [31:0]                rng_state;

  fifo_top uut (
    .clk         (clk),
    .rst         (rst),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_ready  (push_ready),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .push_status (push_status),
    .pop_status  (pop_status)
  );

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input logic pv, input logic pr, input string name);
    pv_tbl.push_back(pv);
    pr_tbl.push_back(pr);
    name_tbl.push_back(name);
  endtask

  task automatic build_table();
    add_row(1'b0, 1'b0, "reset_values");
    // Single item straight through the bypass
    add_row(1'b1, 1'b0, "bypass_push");
    add_row(1'b0, 1'b0, "bypass_hold");
    add_row(1'b0, 1'b1, "bypass_pop");
    add_row(1'b0, 1'b0, "bypass_empty");
    // Extra pushes past DEPTH get refused
    repeat (6) add_row(1'b1, 1'b0, "fill_to_full");
    add_row(1'b0, 1'b0, "full_hold");
    repeat (5) add_row(1'b0, 1'b1, "drain");
    add_row(1'b0, 1'b0, "drain_empty");
    // Steady push and pop, storage address wraps
    repeat (2) add_row(1'b1, 1'b0, "partial_fill");
    repeat (10) add_row(1'b1, 1'b1, "push_pop_wrap");
    repeat (4) add_row(1'b0, 1'b1, "partial_drain");
    for (int n = 0; n < RANDOM_ROWS; n++) begin
      rng_state = xorshift32(rng_state);
      add_row(rng_state[3], rng_state[9], "random");
    end
    repeat (6) add_row(1'b0, 1'b1, "final_drain");
  endtask

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1);
  endtask

  // --------------------
  // Compare tasks
  // --------------------

  task automatic flag_check(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("Fail %s: %s expected %b, actual %b", name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic data_check(input string name, input logic [fifo_pkg::WIDTH-1:0] exp,
                            input logic [fifo_pkg::WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: pop_data expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic push_status_check(input string name, input fifo_pkg::push_status_t exp,
                                   input fifo_pkg::push_status_t act);
    if (act !== exp) begin
      $display("Fail %s: push status expected full=%b slots=%0d, actual full=%b slots=%0d",
               name, exp.full, exp.slots, act.full, act.slots);
      stop_on_error();
    end
  endtask

  task automatic pop_status_check(input string name, input fifo_pkg::pop_status_t exp,
                                  input fifo_pkg::pop_status_t act);
    if (act !== exp) begin
      $display("Fail %s: pop status expected empty=%b items=%0d, actual empty=%b items=%0d",
               name, exp.empty, exp.items, act.empty, act.items);
      stop_on_error();
    end
  endtask

  // --------------------
  // Model
  // --------------------

  // Pop before push, a full queue never takes a beat anyway
  task automatic apply_beats(input logic do_push, input logic do_pop,
                             input logic [fifo_pkg::WIDTH-1:0] data);
    if (do_pop) begin
      void'(model_q.pop_front());
    end
    if (do_push) begin
      model_q.push_back(data);
    end
  endtask

  task automatic compare_outputs(input string name);
    fifo_pkg::push_status_t exp_push;
    fifo_pkg::pop_status_t  exp_pop;
    int                     held;
    held           = model_q.size();
    exp_push.full  = (held == fifo_pkg::DEPTH);
    exp_push.slots = fifo_pkg::COUNT_WIDTH'(fifo_pkg::DEPTH - held);
    exp_pop.empty  = (held == 0);
    exp_pop.items  = fifo_pkg::COUNT_WIDTH'(held);
    flag_check(name, "push_ready", held < fifo_pkg::DEPTH, push_ready);
    flag_check(name, "pop_valid", held != 0, pop_valid);
    push_status_check(name, exp_push, push_status);
    pop_status_check(name, exp_pop, pop_status);
    // Payload only means something with an item held
    if (held != 0) begin
      data_check(name, model_q[0], pop_data);
    end
  endtask

  // --------------------
  // Clock and watchdog
  // --------------------

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Table rows plus reset plus some slack
  initial begin
    wait (table_built);
    #((name_tbl.size() + RESET_CYCLES + MARGIN_ROWS) * CLK_PERIOD);
    $display("Watchdog expired before the stimulus table was finished");
    stop_on_error();
  end

  // Main sequence
  initial begin
    logic                       pend_push;
    logic                       pend_pop;
    logic [fifo_pkg::WIDTH-1:0] pend_data;
    rst         = 1'b1;
    push_valid  = 1'b0;
    push_data   = '0;
    pop_ready   = 1'b0;
    table_built = 1'b0;
    rng_state   = 32'd71;
    pend_push   = 1'b0;
    pend_pop    = 1'b0;
    pend_data   = '0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < name_tbl.size(); i++) begin
      @(posedge clk);
      rng_state = xorshift32(rng_state);
      push_valid <= pv_tbl[i];
      push_data  <= rng_state[fifo_pkg::WIDTH-1:0];
      pop_ready  <= pr_tbl[i];
      // Outputs settled, mid cycle
      @(negedge clk);
      apply_beats(pend_push, pend_pop, pend_data);
      compare_outputs(name_tbl[i]);
      // Beats that the next rising edge will take
      pend_push = push_valid && (model_q.size() < fifo_pkg::DEPTH);
      pend_pop  = pop_ready && (model_q.size() != 0);
      pend_data = push_data;
    end
    $display("All tests passed");
    $finish;
  end

endmodule : fifo_tb
